// ==== riscvPkg.sv ====
package riscvPkg;

    typedef logic [31:0] wordT;     // pc, instruction, operand, result
    typedef logic [4:0]  regAddrT;  // register index

    // encodings follow the decoder's control word
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt
    } aluCtrlT;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immJ,
        immU
    } immSrcT;

    typedef enum logic [1:0] {
        resAlu,
        resMem,
        resPc4   // link value for jal
    } resultSrcT;

    typedef enum logic [1:0] {
        fwdNone,
        fwdW,
        fwdM
    } forwardT;

    // opcodes of the supported subset
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opRType  = 7'b0110011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opIType  = 7'b0010011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opLui    = 7'b0110111;

    localparam int numRegs = 32;

    // all-zero word, decodes with no write and no store
    localparam wordT nopInstr = 32'h0000_0000;

endpackage

// ==== hazardIf.sv ====
`timescale 1ns/1ps

interface hazardIf import riscvPkg::*; ();

    // pipeline side
    regAddrT rs1D, rs2D;
    regAddrT rs1E, rs2E;
    regAddrT rdE, rdM, rdW;
    logic    regWriteM, regWriteW;
    logic    memToRegE;          // load sitting in execute
    logic    pcSrcE;             // taken beq or jal

    // hazard side
    forwardT forwardA, forwardB;
    logic    stallF, stallD;
    logic    flushD, flushE;

    modport pipeline (
        output rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
        output regWriteM, regWriteW, memToRegE, pcSrcE,
        input  forwardA, forwardB, stallF, stallD, flushD, flushE
    );

    modport hazard (
        input  rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
        input  regWriteM, regWriteW, memToRegE, pcSrcE,
        output forwardA, forwardB, stallF, stallD, flushD, flushE
    );

endinterface

// ==== controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit import riscvPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [6:0] opD,
    input  logic [2:0] funct3D,
    input  logic       funct7b5D,
    input  logic       zeroE,
    hazardIf.pipeline  hz,
    output immSrcT     immSrcD,
    output aluCtrlT    aluCtrlE,
    output logic       srcAZeroE,
    output logic       srcBImmE,
    output logic       memWriteM,
    output logic       regWriteW,
    output resultSrcT  resultSrcW
);

    // regWrite_immSrc_srcAZero_srcBImm_memWrite_resultSrc_branch_aluOp_jump
    logic [12:0] controls;

    logic       regWriteD, memWriteD, branchD, jumpD;
    logic       srcAZeroD, srcBImmD;
    resultSrcT  resultSrcD;
    logic [1:0] aluOpD;      // 00 add, 01 sub, 10 by funct3
    aluCtrlT    aluCtrlD;

    logic       regWriteE, memWriteE, branchE, jumpE;
    resultSrcT  resultSrcE;
    logic       regWriteM;
    resultSrcT  resultSrcM;

    always_comb begin
        case (opD)
            opLoad:   controls = 13'b1_000_0_1_0_01_0_00_0;
            opStore:  controls = 13'b0_001_0_1_1_00_0_00_0;
            opRType:  controls = 13'b1_000_0_0_0_00_0_10_0;
            opBranch: controls = 13'b0_010_0_0_0_00_1_01_0;
            opIType:  controls = 13'b1_000_0_1_0_00_0_10_0;
            opJal:    controls = 13'b1_011_0_0_0_10_0_00_1;
            opLui:    controls = 13'b1_100_1_1_0_00_0_00_0;
            default:  controls = '0;  // unknown opcode acts as a no-op
        endcase
    end

    assign regWriteD  = controls[12];
    assign immSrcD    = immSrcT'(controls[11:9]);
    assign srcAZeroD  = controls[8];
    assign srcBImmD   = controls[7];
    assign memWriteD  = controls[6];
    assign resultSrcD = resultSrcT'(controls[5:4]);
    assign branchD    = controls[3];
    assign aluOpD     = controls[2:1];
    assign jumpD      = controls[0];

    // alu decoder
    always_comb begin
        case (aluOpD)
            2'b00: aluCtrlD = aluAdd;
            2'b01: aluCtrlD = aluSub;
            default: begin
                case (funct3D)
                    3'b000:  aluCtrlD = (funct7b5D && opD[5]) ? aluSub : aluAdd;
                    3'b010:  aluCtrlD = aluSlt;
                    3'b100:  aluCtrlD = aluXor;
                    3'b110:  aluCtrlD = aluOr;
                    3'b111:  aluCtrlD = aluAnd;
                    default: aluCtrlD = aluAdd;
                endcase
            end
        endcase
    end

    // execute stage, cleared into a bubble on flushE
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regWriteE  <= 1'b0;
            resultSrcE <= resAlu;
            memWriteE  <= 1'b0;
            branchE    <= 1'b0;
            jumpE      <= 1'b0;
            aluCtrlE   <= aluAdd;
            srcAZeroE  <= 1'b0;
            srcBImmE   <= 1'b0;
        end else if (hz.flushE) begin
            regWriteE  <= 1'b0;
            resultSrcE <= resAlu;
            memWriteE  <= 1'b0;
            branchE    <= 1'b0;
            jumpE      <= 1'b0;
            aluCtrlE   <= aluAdd;
            srcAZeroE  <= 1'b0;
            srcBImmE   <= 1'b0;
        end else begin
            regWriteE  <= regWriteD;
            resultSrcE <= resultSrcD;
            memWriteE  <= memWriteD;
            branchE    <= branchD;
            jumpE      <= jumpD;
            aluCtrlE   <= aluCtrlD;
            srcAZeroE  <= srcAZeroD;
            srcBImmE   <= srcBImmD;
        end
    end

    // memory and writeback stages
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regWriteM  <= 1'b0;
            resultSrcM <= resAlu;
            memWriteM  <= 1'b0;
            regWriteW  <= 1'b0;
            resultSrcW <= resAlu;
        end else begin
            regWriteM  <= regWriteE;
            resultSrcM <= resultSrcE;
            memWriteM  <= memWriteE;
            regWriteW  <= regWriteM;
            resultSrcW <= resultSrcM;
        end
    end

    assign hz.pcSrcE    = (branchE & zeroE) | jumpE;
    assign hz.memToRegE = (resultSrcE == resMem);
    assign hz.regWriteM = regWriteM;
    assign hz.regWriteW = regWriteW;

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile import riscvPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    we,
    input  regAddrT ra1,
    input  regAddrT ra2,
    input  regAddrT wa,
    input  wordT    wd,
    output wordT    rd1,
    output wordT    rd2
);

    wordT regs [numRegs];

    // falling edge write, decode sees the value in the same cycle
    always_ff @(negedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];  // x0 reads zero
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== execUnit.sv ====
`timescale 1ns/1ps

module execUnit import riscvPkg::*; (
    input  wordT      rd1E,
    input  wordT      rd2E,
    input  wordT      immE,
    input  wordT      pcE,
    input  wordT      resultW,
    input  wordT      aluResultM,
    input  aluCtrlT   aluCtrlE,
    input  logic      srcAZeroE,
    input  logic      srcBImmE,
    hazardIf.pipeline hz,
    output wordT      aluResultE,
    output wordT      writeDataE,
    output wordT      pcTargetE,
    output logic      zeroE
);

    wordT fwdAE;
    wordT srcAE;
    wordT srcBE;
    wordT bInv;
    wordT sum;
    logic subOp;
    logic overflow;

    function automatic wordT fwdSel(forwardT sel, wordT regVal, wordT wbVal, wordT memVal);
        case (sel)
            fwdM:    return memVal;
            fwdW:    return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign fwdAE      = fwdSel(hz.forwardA, rd1E, resultW, aluResultM);
    assign writeDataE = fwdSel(hz.forwardB, rd2E, resultW, aluResultM);  // also store data

    assign srcAE = srcAZeroE ? '0 : fwdAE;  // lui is 0 + imm
    assign srcBE = srcBImmE ? immE : writeDataE;

    // shared adder, subtract for sub, slt and beq compare
    assign subOp = (aluCtrlE == aluSub) || (aluCtrlE == aluSlt);
    assign bInv  = subOp ? ~srcBE : srcBE;
    assign sum   = srcAE + bInv + {31'b0, subOp};

    // signed overflow of a - b
    assign overflow = (srcAE[31] ^ srcBE[31]) & (srcAE[31] ^ sum[31]);

    always_comb begin
        case (aluCtrlE)
            aluAnd:  aluResultE = srcAE & srcBE;
            aluOr:   aluResultE = srcAE | srcBE;
            aluXor:  aluResultE = srcAE ^ srcBE;
            aluSlt:  aluResultE = {31'b0, sum[31] ^ overflow};
            default: aluResultE = sum;  // add, sub
        endcase
    end

    assign zeroE     = (aluResultE == '0);
    assign pcTargetE = pcE + immE;  // beq and jal target

endmodule

// ==== hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit import riscvPkg::*; (
    hazardIf.hazard hz
);

    logic lwStall;

    // memory stage result is newer, so it wins over writeback
    function automatic forwardT pickFwd(
        regAddrT rs,
        regAddrT rdM,
        regAddrT rdW,
        logic    regWriteM,
        logic    regWriteW
    );
        if (rs == '0) begin
            return fwdNone;
        end else if (regWriteM && rs == rdM) begin
            return fwdM;
        end else if (regWriteW && rs == rdW) begin
            return fwdW;
        end
        return fwdNone;
    endfunction

    assign hz.forwardA = pickFwd(hz.rs1E, hz.rdM, hz.rdW, hz.regWriteM, hz.regWriteW);
    assign hz.forwardB = pickFwd(hz.rs2E, hz.rdM, hz.rdW, hz.regWriteM, hz.regWriteW);

    // load in execute whose destination is read by decode
    assign lwStall = hz.memToRegE && (hz.rs1D == hz.rdE || hz.rs2D == hz.rdE);

    assign hz.stallF = lwStall;
    assign hz.stallD = lwStall;
    assign hz.flushD = hz.pcSrcE;             // squash the two younger instructions
    assign hz.flushE = lwStall || hz.pcSrcE;  // bubble during the load-use stall

endmodule

// ==== riscvCore.sv ====
`timescale 1ns/1ps

module riscvCore import riscvPkg::*; (
    input  logic clk,
    input  logic reset,
    output wordT pc,
    input  wordT instr,
    output logic memWrite,
    output wordT aluResult,
    output wordT writeData,
    input  wordT readData
);

    hazardIf hz ();

    // fetch
    wordT       pcNext, pcPlus4F;
    // decode
    wordT       instrD, pcD, pcPlus4D;
    wordT       rd1D, rd2D, immD;
    logic [6:0] opD;
    logic [2:0] funct3D;
    logic       funct7b5D;
    regAddrT    rs1D, rs2D, rdD;
    immSrcT     immSrcD;
    // execute
    wordT       rd1E, rd2E, pcE, immE, pcPlus4E;
    regAddrT    rs1E, rs2E, rdE;
    aluCtrlT    aluCtrlE;
    logic       srcAZeroE, srcBImmE, zeroE;
    wordT       aluResultE, writeDataE, pcTargetE;
    // memory
    wordT       aluResultM, writeDataM, pcPlus4M;
    regAddrT    rdM;
    logic       memWriteM;
    // writeback
    wordT       aluResultW, readDataW, pcPlus4W, resultW;
    regAddrT    rdW;
    logic       regWriteW;
    resultSrcT  resultSrcW;

    assign pcPlus4F = pc + 32'd4;
    assign pcNext   = hz.pcSrcE ? pcTargetE : pcPlus4F;  // redirect from execute

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (!hz.stallF) begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instrD <= nopInstr;
        end else if (hz.flushD) begin
            instrD <= nopInstr;
        end else if (!hz.stallD) begin
            instrD <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!hz.stallD) begin
            pcD      <= pc;
            pcPlus4D <= pcPlus4F;
        end
    end

    // instruction fields
    assign opD       = instrD[6:0];
    assign funct3D   = instrD[14:12];
    assign funct7b5D = instrD[30];
    assign rs1D      = instrD[19:15];
    assign rs2D      = instrD[24:20];
    assign rdD       = instrD[11:7];

    always_comb begin
        case (immSrcD)
            immS:    immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immB:    immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            immJ:    immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            immU:    immD = {instrD[31:12], 12'b0};
            default: immD = {{20{instrD[31]}}, instrD[31:20]};  // I-type
        endcase
    end

    // execute, memory and writeback data registers
    always_ff @(posedge clk) begin
        rd1E       <= rd1D;
        rd2E       <= rd2D;
        pcE        <= pcD;
        immE       <= immD;
        pcPlus4E   <= pcPlus4D;
        rs1E       <= rs1D;
        rs2E       <= rs2D;
        rdE        <= rdD;

        aluResultM <= aluResultE;
        writeDataM <= writeDataE;
        pcPlus4M   <= pcPlus4E;
        rdM        <= rdE;

        aluResultW <= aluResultM;
        readDataW  <= readData;
        pcPlus4W   <= pcPlus4M;
        rdW        <= rdM;
    end

    always_comb begin
        case (resultSrcW)
            resMem:  resultW = readDataW;
            resPc4:  resultW = pcPlus4W;
            default: resultW = aluResultW;
        endcase
    end

    assign hz.rs1D = rs1D;
    assign hz.rs2D = rs2D;
    assign hz.rs1E = rs1E;
    assign hz.rs2E = rs2E;
    assign hz.rdE  = rdE;
    assign hz.rdM  = rdM;
    assign hz.rdW  = rdW;

    assign memWrite  = memWriteM;
    assign aluResult = aluResultM;
    assign writeData = writeDataM;

    controlUnit i_ctrl (
        .clk        (clk),
        .reset      (reset),
        .opD        (opD),
        .funct3D    (funct3D),
        .funct7b5D  (funct7b5D),
        .zeroE      (zeroE),
        .hz         (hz),
        .immSrcD    (immSrcD),
        .aluCtrlE   (aluCtrlE),
        .srcAZeroE  (srcAZeroE),
        .srcBImmE   (srcBImmE),
        .memWriteM  (memWriteM),
        .regWriteW  (regWriteW),
        .resultSrcW (resultSrcW)
    );

    regFile i_regs (
        .clk   (clk),
        .reset (reset),
        .we    (regWriteW),
        .ra1   (rs1D),
        .ra2   (rs2D),
        .wa    (rdW),
        .wd    (resultW),
        .rd1   (rd1D),
        .rd2   (rd2D)
    );

    execUnit i_exec (
        .rd1E       (rd1E),
        .rd2E       (rd2E),
        .immE       (immE),
        .pcE        (pcE),
        .resultW    (resultW),
        .aluResultM (aluResultM),
        .aluCtrlE   (aluCtrlE),
        .srcAZeroE  (srcAZeroE),
        .srcBImmE   (srcBImmE),
        .hz         (hz),
        .aluResultE (aluResultE),
        .writeDataE (writeDataE),
        .pcTargetE  (pcTargetE),
        .zeroE      (zeroE)
    );

    hazardUnit i_hazard (
        .hz (hz)
    );

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic reset
);

    localparam realtime halfPeriod = 4ns;  // 8 ns clock

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    // reset held for two rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== riscvTb.sv ====
`timescale 1ns/1ps

module riscvTb import riscvPkg::*; ();

    localparam int romDepth = 256;
    localparam int ramDepth = 64;

    logic clk;
    logic reset;
    wordT pc;
    wordT instr;
    logic memWrite;
    wordT aluResult;
    wordT writeData;
    wordT readData;

    wordT rom [romDepth];
    wordT dmem [ramDepth];
    wordT refRegs [numRegs];
    wordT refMem [ramDepth];
    wordT expAddr [$];
    wordT expData [$];

    integer seed = 32'he4c6_845d;
    int   progLen;
    int   storeOff;
    int   errors;
    int   gotStores;
    int   expCount;
    wordT haltPc;
    logic progReady = 1'b0;

    tbClock i_clk (
        .clk   (clk),
        .reset (reset)
    );

    riscvCore i_dut (
        .clk       (clk),
        .reset     (reset),
        .pc        (pc),
        .instr     (instr),
        .memWrite  (memWrite),
        .aluResult (aluResult),
        .writeData (writeData),
        .readData  (readData)
    );

    // instruction encoders
    function automatic wordT encR(logic [6:0] f7, logic [2:0] f3, regAddrT rd,
                                  regAddrT rs1, regAddrT rs2);
        return {f7, rs2, rs1, f3, rd, opRType};
    endfunction

    function automatic wordT encI(logic [6:0] op, logic [2:0] f3, regAddrT rd,
                                  regAddrT rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic wordT encS(regAddrT rs2, regAddrT rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
    endfunction

    function automatic wordT encB(regAddrT rs1, regAddrT rs2, logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic wordT encJ(regAddrT rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    function automatic wordT encU(regAddrT rd, logic [19:0] imm);
        return {imm, rd, opLui};
    endfunction

    function automatic wordT fillWord(int idx);
        return (wordT'(idx) * 32'h0102_0409) ^ 32'h5a5a_0000;
    endfunction

    task automatic emit(input wordT w);
        rom[progLen] = w;
        progLen++;
    endtask

    task automatic storeReg(input regAddrT r);
        emit(encS(r, 5'd0, storeOff));
        storeOff += 4;  // every sw gets its own word
    endtask

    task automatic loadConst(input regAddrT r, input wordT v);
        wordT hi;
        hi = v + 32'h800;  // addi sign-extends the low part
        emit(encU(r, hi[31:12]));
        emit(encI(opIType, 3'b000, r, r, v[11:0]));
    endtask

    task automatic buildProgram();
        progLen  = 0;
        storeOff = 0;
        for (int r = 1; r <= 6; r++) begin
            loadConst(regAddrT'(r), $random(seed));
        end
        emit(encI(opIType, 3'b000, 5'd7, 5'd0, -5));
        emit(encI(opIType, 3'b000, 5'd8, 5'd0, 3));
        for (int r = 1; r <= 8; r++) begin
            storeReg(regAddrT'(r));
        end

        // arithmetic and logic
        emit(encR(7'h00, 3'b000, 5'd10, 5'd1, 5'd2));
        emit(encR(7'h20, 3'b000, 5'd11, 5'd1, 5'd2));
        emit(encR(7'h00, 3'b111, 5'd12, 5'd3, 5'd4));
        emit(encR(7'h00, 3'b110, 5'd13, 5'd3, 5'd4));
        emit(encR(7'h00, 3'b100, 5'd14, 5'd5, 5'd6));
        emit(encR(7'h00, 3'b010, 5'd15, 5'd7, 5'd8));  // -5 < 3
        emit(encR(7'h00, 3'b010, 5'd16, 5'd8, 5'd7));
        emit(encR(7'h00, 3'b010, 5'd17, 5'd1, 5'd2));
        emit(encI(opIType, 3'b000, 5'd18, 5'd1, -123));
        emit(encI(opIType, 3'b111, 5'd19, 5'd2, 12'h7f0));
        emit(encI(opIType, 3'b110, 5'd20, 5'd3, -256));
        emit(encI(opIType, 3'b100, 5'd21, 5'd4, 12'h555));
        emit(encI(opIType, 3'b010, 5'd22, 5'd7, -4));
        emit(encI(opIType, 3'b010, 5'd23, 5'd5, 100));
        for (int r = 10; r <= 23; r++) begin
            storeReg(regAddrT'(r));
        end

        // dependent chains at distance one and two
        emit(encR(7'h00, 3'b000, 5'd10, 5'd1, 5'd2));
        emit(encR(7'h00, 3'b000, 5'd11, 5'd10, 5'd3));
        emit(encR(7'h20, 3'b000, 5'd12, 5'd11, 5'd10));
        storeReg(5'd12);
        emit(encR(7'h00, 3'b100, 5'd13, 5'd12, 5'd11));
        emit(encR(7'h00, 3'b111, 5'd14, 5'd13, 5'd13));
        storeReg(5'd14);
        storeReg(5'd11);
        storeReg(5'd13);

        // load-use
        emit(encI(opLoad, 3'b010, 5'd14, 5'd0, 200));
        emit(encR(7'h00, 3'b000, 5'd15, 5'd14, 5'd1));
        storeReg(5'd15);
        emit(encI(opLoad, 3'b010, 5'd16, 5'd0, 204));
        storeReg(5'd16);                                // loaded value as store data
        emit(encI(opIType, 3'b000, 5'd9, 5'd0, 208));
        emit(encI(opLoad, 3'b010, 5'd17, 5'd9, 4));
        emit(encR(7'h00, 3'b000, 5'd18, 5'd17, 5'd17));
        storeReg(5'd18);
        emit(encI(opLoad, 3'b010, 5'd19, 5'd0, 0));     // reads back the first store
        storeReg(5'd19);

        // branches and jumps, skipped stores must never show up
        emit(encB(5'd1, 5'd1, 12));
        storeReg(5'd1);
        storeReg(5'd2);
        storeReg(5'd3);
        emit(encB(5'd7, 5'd8, 8));                      // not taken
        storeReg(5'd7);
        emit(encJ(5'd24, 12));
        storeReg(5'd5);
        storeReg(5'd6);
        storeReg(5'd24);                                // link value
        emit(encI(opIType, 3'b000, 5'd25, 5'd7, 0));
        emit(encB(5'd25, 5'd7, 12));                    // operand forwarded into beq
        storeReg(5'd1);
        storeReg(5'd2);
        storeReg(5'd25);

        // lui and writes to x0
        emit(encU(5'd27, 20'habcde));
        storeReg(5'd27);
        emit(encI(opIType, 3'b000, 5'd0, 5'd1, 5));
        emit(encR(7'h00, 3'b000, 5'd28, 5'd0, 5'd1));
        storeReg(5'd28);
        storeReg(5'd0);

        haltPc = wordT'(progLen * 4);
        emit(encJ(5'd0, 0));  // jal to itself
    endtask

    function automatic wordT refAlu(logic [2:0] f3, logic isSub, wordT a, wordT b);
        case (f3)
            3'b000:  return isSub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    // one instruction of the ISA model, returns the next pc
    function automatic wordT refStep(wordT pcIn, wordT ins);
        wordT    a;
        wordT    b;
        wordT    addr;
        wordT    res;
        wordT    nextPc;
        wordT    immI;
        wordT    immS;
        wordT    immB;
        wordT    immJ;
        logic    wr;
        regAddrT rd;
        a      = refRegs[ins[19:15]];
        b      = refRegs[ins[24:20]];
        rd     = ins[11:7];
        immI   = {{20{ins[31]}}, ins[31:20]};
        immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        nextPc = pcIn + 32'd4;
        wr     = 1'b0;
        res    = '0;
        case (ins[6:0])
            opLui: begin
                wr  = 1'b1;
                res = {ins[31:12], 12'b0};
            end
            opIType: begin
                wr  = 1'b1;
                res = refAlu(ins[14:12], 1'b0, a, immI);
            end
            opRType: begin
                wr  = 1'b1;
                res = refAlu(ins[14:12], ins[30], a, b);
            end
            opLoad: begin
                wr   = 1'b1;
                addr = a + immI;
                res  = refMem[addr[7:2]];
            end
            opStore: begin
                addr = a + immS;
                expAddr.push_back(addr);
                expData.push_back(b);
                refMem[addr[7:2]] = b;
            end
            opBranch: begin
                if (a == b) nextPc = pcIn + immB;
            end
            opJal: begin
                wr     = 1'b1;
                res    = pcIn + 32'd4;
                nextPc = pcIn + immJ;
            end
            default: ;  // anything else is a no-op
        endcase
        if (wr && rd != '0) refRegs[rd] = res;
        return nextPc;
    endfunction

    task automatic runReference();
        wordT pcRef;
        wordT nextPc;
        pcRef = '0;
        for (int step = 0; step < 10 * romDepth; step++) begin
            nextPc = refStep(pcRef, rom[pcRef[9:2]]);
            if (nextPc == pcRef) break;  // reached the halt loop
            pcRef = nextPc;
        end
    endtask

    task automatic checkStore(input wordT addr, input wordT data);
        wordT ea;
        wordT ed;
        gotStores++;
        if (expAddr.size() == 0) begin
            errors++;
            $display("too many stores: store %0d to address %h was not expected", gotStores, addr);
        end else begin
            ea = expAddr.pop_front();
            ed = expData.pop_front();
            if (addr !== ea || data !== ed) begin
                errors++;
                $display("** Error @ %0t: store %0d expected [%h] = %h, got [%h] = %h",
                         $time, gotStores, ea, ed, addr, data);
            end
        end
    endtask

    // memory responses driven on the falling edge
    always @(negedge clk) begin
        instr    <= rom[pc[9:2]];
        readData <= dmem[aluResult[7:2]];
    end

    always @(posedge clk) begin
        if (memWrite) dmem[aluResult[7:2]] <= writeData;
    end

    always @(negedge clk) begin
        if (!reset && memWrite === 1'b1) checkStore(aluResult, writeData);
    end

    initial begin
        instr     = nopInstr;
        readData  = '0;
        errors    = 0;
        gotStores = 0;
        foreach (rom[i]) rom[i] = nopInstr;
        foreach (dmem[i]) begin
            dmem[i]   = fillWord(i);
            refMem[i] = fillWord(i);
        end
        foreach (refRegs[i]) refRegs[i] = '0;
        buildProgram();
        runReference();
        expCount  = expAddr.size();
        progReady = 1'b1;

        @(negedge reset);
        while (pc !== haltPc) @(negedge clk);
        repeat (8) @(negedge clk);  // let the last stores leave the pipe

        if (gotStores < expCount) begin
            errors++;
            $display("too few stores: saw %0d of %0d", gotStores, expCount);
        end
        $display("errors: %0d, stores: %0d of %0d", errors, gotStores, expCount);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog scaled to the program length
    initial begin
        wait (progReady);
        repeat (20 * progLen + 100) @(posedge clk);
        $display("timeout: halt loop not reached after %0d cycles", 20 * progLen + 100);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== list.f ====
riscvPkg.sv
hazardIf.sv
controlUnit.sv
regFile.sv
execUnit.sv
hazardUnit.sv
riscvCore.sv
tbClock.sv
riscvTb.sv

// ==== Bender.yml ====
package:
  name: riscv_core

sources:
  - riscvPkg.sv
  - hazardIf.sv
  - controlUnit.sv
  - regFile.sv
  - execUnit.sv
  - hazardUnit.sv
  - riscvCore.sv
  - target: test
    files:
      - tbClock.sv
      - riscvTb.sv
